// File: rtl/board_pkg.sv
// APB request and response structs, button struct, address map and register offsets.

package board_pkg;

    // Master to slave.
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // Slave to master.
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Board buttons, u in bit 0.
    typedef struct packed {
        logic c;
        logic r;
        logic l;
        logic d;
        logic u;
    } btn_t;

    // Page select, paddr bits 11 to 8.
    localparam logic [3:0] GPIO_PAGE = 4'h0;
    localparam logic [3:0] PMU_PAGE  = 4'h1;

    // GPIO block.
    localparam logic [7:0] OFS_GPIO_OUT = 8'h00;
    localparam logic [7:0] OFS_GPIO_OE  = 8'h04;
    localparam logic [7:0] OFS_GPIO_IN  = 8'h08;
    localparam logic [7:0] OFS_BTN_SW   = 8'h0C;

    // Power management block.
    localparam logic [7:0] OFS_PMU_CTRL = 8'h00;
    localparam logic [7:0] OFS_PMU_RTC  = 8'h04;

endpackage

// File: rtl/input_debounce.sv
// Two-flop synchronizer and stability counter debouncer for a packed payload.

`timescale 1ns/1ps

module input_debounce #(
    parameter int  debounce_cycles = 250000,
    parameter type payload_t       = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t raw,
    output payload_t clean
);
    localparam int cnt_w = $clog2(debounce_cycles + 1);

    payload_t             sync1;
    payload_t             sync2;
    payload_t             prev;
    logic [cnt_w-1:0]     cnt;
    logic                 stable;

    assign stable = (cnt == cnt_w'(debounce_cycles));

    always_ff @(posedge clk) begin
        if (rst) begin
            sync1 <= '0;
            sync2 <= '0;
            prev  <= '0;
            cnt   <= '0;
            clean <= '0;
        end else begin
            sync1 <= raw;
            sync2 <= sync1;
            prev  <= sync2;
            // New sample counts as its first stable cycle.
            if (sync2 != prev) begin
                cnt <= cnt_w'(1);
            end else if (!stable) begin
                cnt <= cnt + 1'b1;
            end
            if (stable) begin
                clean <= prev;
            end
        end
    end

endmodule

// File: rtl/gpio_regs.sv
// GPIO register block with output, output enable, input pins and debounced buttons and switches.

`timescale 1ns/1ps

module gpio_regs (
    input  logic                clk,
    input  logic                rst,
    input  board_pkg::apb_req_t req,
    output board_pkg::apb_rsp_t rsp,
    input  logic [31:0]         gpio_in,
    input  board_pkg::btn_t     btn,
    input  logic [7:0]          sw,
    output logic [31:0]         gpio_out,
    output logic [31:0]         gpio_oe
);
    logic        access;
    logic [7:0]  ofs;
    logic        err;
    logic        wr_ok;
    logic [31:0] rdata;

    assign access = req.psel && req.penable;
    assign ofs    = req.paddr[7:0];

    // Read mux and error decode.
    always_comb begin
        err   = 1'b0;
        rdata = '0;
        case (ofs)
            board_pkg::OFS_GPIO_OUT: begin
                rdata = gpio_out;
            end
            board_pkg::OFS_GPIO_OE: begin
                rdata = gpio_oe;
            end
            board_pkg::OFS_GPIO_IN: begin
                rdata = gpio_in;
                err   = req.pwrite;
            end
            board_pkg::OFS_BTN_SW: begin
                rdata = {19'd0, btn, sw};
                err   = req.pwrite;
            end
            default: begin
                err = 1'b1;
            end
        endcase
    end

    assign wr_ok = access && req.pwrite && !err;

    // Zero wait states.
    always_comb begin
        rsp.prdata  = rdata;
        rsp.pready  = access;
        rsp.pslverr = access && err;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gpio_out <= '0;
            gpio_oe  <= '0;
        end else if (wr_ok) begin
            if (ofs == board_pkg::OFS_GPIO_OUT) begin
                gpio_out <= req.pwdata;
            end
            if (ofs == board_pkg::OFS_GPIO_OE) begin
                gpio_oe <= req.pwdata;
            end
        end
    end

endmodule

// File: rtl/pmu_regs.sv
// Power management registers with shutdown, core reset request and real-time tick counter.

`timescale 1ns/1ps

module pmu_regs #(
    parameter int rtc_div = 25000
) (
    input  logic                clk,
    input  logic                rst,
    input  board_pkg::apb_req_t req,
    output board_pkg::apb_rsp_t rsp,
    input  logic                btn_c,
    output logic                core_en,
    output logic                core_rst
);
    localparam int pre_w = $clog2(rtc_div + 1);

    logic             access;
    logic [7:0]       ofs;
    logic             err;
    logic             wr_ctrl;
    logic             wr_rtc;
    logic [31:0]      rdata;
    logic             shdn;
    logic             rst_req;
    logic [pre_w-1:0] pre;
    logic [31:0]      rtc;

    assign access = req.psel && req.penable;
    assign ofs    = req.paddr[7:0];

    always_comb begin
        err   = 1'b0;
        rdata = '0;
        case (ofs)
            board_pkg::OFS_PMU_CTRL: rdata = {30'd0, 1'b0, shdn};
            board_pkg::OFS_PMU_RTC:  rdata = rtc;
            default:                 err   = 1'b1;
        endcase
    end

    assign wr_ctrl = access && req.pwrite && (ofs == board_pkg::OFS_PMU_CTRL);
    assign wr_rtc  = access && req.pwrite && (ofs == board_pkg::OFS_PMU_RTC);

    always_comb begin
        rsp.prdata  = rdata;
        rsp.pready  = access;
        rsp.pslverr = access && err;
    end

    // Center button wakes the core and holds it in reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            shdn    <= 1'b0;
            rst_req <= 1'b1;
        end else begin
            if (btn_c) begin
                shdn <= 1'b0;
            end else if (wr_ctrl && req.pwdata[0]) begin
                shdn <= 1'b1;
            end
            rst_req <= wr_ctrl && req.pwdata[1];
        end
    end

    assign core_en  = !shdn;
    assign core_rst = rst || rst_req || btn_c;

    // Tick counter, frozen during shutdown.
    always_ff @(posedge clk) begin
        if (rst) begin
            pre <= '0;
            rtc <= '0;
        end else if (wr_rtc) begin
            pre <= '0;
            rtc <= req.pwdata;
        end else if (!shdn) begin
            if (pre == pre_w'(rtc_div - 1)) begin
                pre <= '0;
                rtc <= rtc + 32'd1;
            end else begin
                pre <= pre + 1'b1;
            end
        end
    end

endmodule

// File: rtl/apb_periph_mux.sv
// APB page decoder and response combiner for the GPIO and power management blocks.

`timescale 1ns/1ps

module apb_periph_mux (
    input  board_pkg::apb_req_t req,
    output board_pkg::apb_rsp_t rsp,
    output board_pkg::apb_req_t gpio_req,
    input  board_pkg::apb_rsp_t gpio_rsp,
    output board_pkg::apb_req_t pmu_req,
    input  board_pkg::apb_rsp_t pmu_rsp
);
    logic [3:0] page;
    logic       gpio_sel;
    logic       pmu_sel;
    logic       access;

    assign page     = req.paddr[11:8];
    assign gpio_sel = (page == board_pkg::GPIO_PAGE);
    assign pmu_sel  = (page == board_pkg::PMU_PAGE);
    assign access   = req.psel && req.penable;

    // Only the addressed slave sees psel.
    always_comb begin
        gpio_req      = req;
        gpio_req.psel = req.psel && gpio_sel;
        pmu_req       = req;
        pmu_req.psel  = req.psel && pmu_sel;
    end

    always_comb begin
        if (gpio_sel) begin
            rsp = gpio_rsp;
        end else if (pmu_sel) begin
            rsp = pmu_rsp;
        end else begin
            // Unmapped page answers with an error.
            rsp.prdata  = '0;
            rsp.pready  = access;
            rsp.pslverr = access;
        end
    end

endmodule

// File: rtl/board_ctl_top.sv
// Board control top level with input debouncers, GPIO and power management blocks and LEDs.

`timescale 1ns/1ps

module board_ctl_top #(
    parameter int debounce_cycles = 250000,
    parameter int rtc_div         = 25000
) (
    input  logic                clk,
    input  logic                rst,
    input  board_pkg::apb_req_t apb_req,
    output board_pkg::apb_rsp_t apb_rsp,
    input  board_pkg::btn_t     btn,
    input  logic [7:0]          sw,
    input  logic [31:0]         gpio_in,
    output logic [31:0]         gpio_out,
    output logic [31:0]         gpio_oe,
    output logic [7:0]          led,
    output logic                core_en,
    output logic                core_rst
);
    board_pkg::btn_t     btn_clean;
    logic [7:0]          sw_clean;
    board_pkg::apb_req_t gpio_req;
    board_pkg::apb_rsp_t gpio_rsp;
    board_pkg::apb_req_t pmu_req;
    board_pkg::apb_rsp_t pmu_rsp;

    input_debounce #(
        .debounce_cycles(debounce_cycles),
        .payload_t      (board_pkg::btn_t)
    ) btn_db (
        .clk  (clk),
        .rst  (rst),
        .raw  (btn),
        .clean(btn_clean)
    );

    input_debounce #(
        .debounce_cycles(debounce_cycles),
        .payload_t      (logic [7:0])
    ) sw_db (
        .clk  (clk),
        .rst  (rst),
        .raw  (sw),
        .clean(sw_clean)
    );

    apb_periph_mux u_mux (
        .req     (apb_req),
        .rsp     (apb_rsp),
        .gpio_req(gpio_req),
        .gpio_rsp(gpio_rsp),
        .pmu_req (pmu_req),
        .pmu_rsp (pmu_rsp)
    );

    gpio_regs u_gpio (
        .clk     (clk),
        .rst     (rst),
        .req     (gpio_req),
        .rsp     (gpio_rsp),
        .gpio_in (gpio_in),
        .btn     (btn_clean),
        .sw      (sw_clean),
        .gpio_out(gpio_out),
        .gpio_oe (gpio_oe)
    );

    pmu_regs #(
        .rtc_div(rtc_div)
    ) u_pmu (
        .clk     (clk),
        .rst     (rst),
        .req     (pmu_req),
        .rsp     (pmu_rsp),
        .btn_c   (btn_clean.c),
        .core_en (core_en),
        .core_rst(core_rst)
    );

    // Status LEDs, then six GPIO outputs.
    assign led = {gpio_out[5:0], ~core_en, core_rst};

endmodule

// File: dv/board_ctl_tb.sv
// Directed testbench for the board control subsystem with APB driver, compare tasks and watchdog.

`timescale 1ns/1ps

module board_ctl_tb;
    localparam int watchdog_cycles = 4000;

    logic                clk;
    logic                rst;
    board_pkg::apb_req_t apb_req;
    board_pkg::apb_rsp_t apb_rsp;
    board_pkg::btn_t     btn;
    logic [7:0]          sw;
    logic [31:0]         gpio_in;
    logic [31:0]         gpio_out;
    logic [31:0]         gpio_oe;
    logic [7:0]          led;
    logic                core_en;
    logic                core_rst;
    logic [31:0]         lcg_state;
    logic [31:0]         out_written;
    int                  errors;
    int                  fails;
    logic                rst_watch;
    logic                rst_seen;
    int                  rst_pulses;

    board_ctl_top #(
        .debounce_cycles(4),
        .rtc_div        (10)
    ) dut0 (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .btn     (btn),
        .sw      (sw),
        .gpio_in (gpio_in),
        .gpio_out(gpio_out),
        .gpio_oe (gpio_oe),
        .led     (led),
        .core_en (core_en),
        .core_rst(core_rst)
    );

    always #50 clk = ~clk;

    // Counts core_rst cycles once an access phase has been seen.
    always @(negedge clk) begin
        if (rst_watch && apb_req.psel && apb_req.penable) begin
            rst_seen = 1'b1;
        end
        if (rst_seen && core_rst) begin
            rst_pulses++;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_btn(input string name, input board_pkg::btn_t exp,
                             input board_pkg::btn_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // Setup phase, then access phase until pready, sampled at the falling edge.
    task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic slverr);
        int waited;
        waited = 0;
        @(posedge clk);
        #5;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        #5;
        apb_req.penable = 1'b1;
        do begin
            @(negedge clk);
            waited++;
        end while (!apb_rsp.pready && waited < 8);
        if (!apb_rsp.pready) begin
            fails++;
            $display("APB transfer to %h got no pready at %0t", addr, $time);
        end
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge clk);
        #5;
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic slverr);
        apb_access(1'b1, addr, wdata, rdata, slverr);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] rdata,
                            output logic slverr);
        apb_access(1'b0, addr, 32'd0, rdata, slverr);
    endtask

    task automatic test_gpio_rw();
        logic [31:0] out_val;
        logic [31:0] oe_val;
        logic [31:0] rd;
        logic        err;
        out_val     = next_rand();
        oe_val      = next_rand();
        out_written = out_val;
        apb_write({board_pkg::GPIO_PAGE, board_pkg::OFS_GPIO_OUT}, out_val, rd, err);
        check_bit("pslverr", 1'b0, err);
        apb_write({board_pkg::GPIO_PAGE, board_pkg::OFS_GPIO_OE}, oe_val, rd, err);
        check_bit("pslverr", 1'b0, err);
        apb_read({board_pkg::GPIO_PAGE, board_pkg::OFS_GPIO_OUT}, rd, err);
        check_word("OUT", out_val, rd);
        apb_read({board_pkg::GPIO_PAGE, board_pkg::OFS_GPIO_OE}, rd, err);
        check_word("OE", oe_val, rd);
        check_word("gpio_out", out_val, gpio_out);
        check_word("gpio_oe", oe_val, gpio_oe);
        check_word("led[7:2]", {26'd0, out_val[5:0]}, {26'd0, led[7:2]});
    endtask

    task automatic test_read_only();
        logic [31:0] rd;
        logic        err;
        gpio_in = next_rand();
        apb_read({board_pkg::GPIO_PAGE, board_pkg::OFS_GPIO_IN}, rd, err);
        check_word("IN", gpio_in, rd);
        check_bit("pslverr", 1'b0, err);
        apb_write({board_pkg::GPIO_PAGE, board_pkg::OFS_GPIO_IN}, next_rand(), rd, err);
        check_bit("pslverr IN write", 1'b1, err);
        apb_write({board_pkg::GPIO_PAGE, board_pkg::OFS_BTN_SW}, next_rand(), rd, err);
        check_bit("pslverr BTN_SW write", 1'b1, err);
        apb_write({board_pkg::GPIO_PAGE, 8'h10}, next_rand(), rd, err);
        check_bit("pslverr bad offset", 1'b1, err);
        apb_write({4'h5, board_pkg::OFS_GPIO_OUT}, next_rand(), rd, err);
        check_bit("pslverr page 5", 1'b1, err);
        apb_read({board_pkg::GPIO_PAGE, board_pkg::OFS_GPIO_OUT}, rd, err);
        check_word("OUT after errors", out_written, rd);
    endtask

    task automatic test_debounce();
        board_pkg::btn_t press;
        logic [31:0]     rd;
        logic            err;
        press   = '0;
        press.c = 1'b1;
        btn     = press;
        sw      = 8'hA5;
        repeat (2) @(posedge clk);
        #5;
        btn = '0;
        sw  = '0;
        // A glitch through the debouncer would show on core_rst.
        repeat (12) begin
            @(negedge clk);
            check_bit("core_rst during glitch", 1'b0, core_rst);
        end
        apb_read({board_pkg::GPIO_PAGE, board_pkg::OFS_BTN_SW}, rd, err);
        check_word("BTN_SW after glitch", 32'd0, rd);
        btn = press;
        sw  = 8'hA5;
        repeat (12) @(posedge clk);
        apb_read({board_pkg::GPIO_PAGE, board_pkg::OFS_BTN_SW}, rd, err);
        check_btn("BTN_SW buttons", press, rd[12:8]);
        check_word("BTN_SW held", {19'd0, press, 8'hA5}, rd);
        btn = '0;
        sw  = '0;
        repeat (12) @(posedge clk);
        apb_read({board_pkg::GPIO_PAGE, board_pkg::OFS_BTN_SW}, rd, err);
        check_word("BTN_SW released", 32'd0, rd);
    endtask

    task automatic test_shutdown();
        logic [31:0] rtc0;
        logic [31:0] rd;
        logic        err;
        int          waited;
        apb_write({board_pkg::PMU_PAGE, board_pkg::OFS_PMU_CTRL}, 32'd1, rd, err);
        check_bit("core_en", 1'b0, core_en);
        apb_read({board_pkg::PMU_PAGE, board_pkg::OFS_PMU_CTRL}, rd, err);
        check_word("CTRL", 32'd1, rd);
        check_bit("led[1]", 1'b1, led[1]);
        apb_read({board_pkg::PMU_PAGE, board_pkg::OFS_PMU_RTC}, rtc0, err);
        repeat (50) @(posedge clk);
        apb_read({board_pkg::PMU_PAGE, board_pkg::OFS_PMU_RTC}, rd, err);
        check_word("RTC in shutdown", rtc0, rd);
        btn.c  = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!core_en && waited < 20);
        if (!core_en) begin
            fails++;
            $display("core_en stayed low while the center button was held");
        end
        repeat (3) begin
            @(negedge clk);
            check_bit("core_rst while held", 1'b1, core_rst);
            check_bit("led[0]", 1'b1, led[0]);
        end
        @(posedge clk);
        #5;
        btn    = '0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (core_rst && waited < 20);
        if (core_rst) begin
            fails++;
            $display("core_rst stayed high after the center button was released");
        end
    endtask

    task automatic test_reset_request();
        logic [31:0] rd;
        logic        err;
        rst_pulses = 0;
        rst_seen   = 1'b0;
        rst_watch  = 1'b1;
        apb_write({board_pkg::PMU_PAGE, board_pkg::OFS_PMU_CTRL}, 32'd2, rd, err);
        repeat (6) @(negedge clk);
        rst_watch = 1'b0;
        rst_seen  = 1'b0;
        check_word("core_rst cycles", 32'd1, rst_pulses);
        apb_read({board_pkg::PMU_PAGE, board_pkg::OFS_PMU_CTRL}, rd, err);
        check_word("CTRL after reset request", 32'd0, rd);
    endtask

    task automatic test_rtc_rate();
        logic [31:0] wr_val;
        logic [31:0] rd;
        logic [31:0] diff;
        logic [31:0] nominal;
        logic        err;
        int          k;
        wr_val  = next_rand();
        k       = 50 + int'(next_rand() % 32'd151);
        nominal = k / 10;
        apb_write({board_pkg::PMU_PAGE, board_pkg::OFS_PMU_RTC}, wr_val, rd, err);
        repeat (k) @(posedge clk);
        apb_read({board_pkg::PMU_PAGE, board_pkg::OFS_PMU_RTC}, rd, err);
        diff = rd - wr_val;
        // Allowed window is one tick either side of k / 10.
        if (diff + 32'd1 - nominal > 32'd2) begin
            check_word("RTC ticks", nominal, diff);
        end
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        apb_req     = '0;
        btn         = '0;
        sw          = '0;
        gpio_in     = '0;
        lcg_state   = 32'd56;
        out_written = '0;
        errors      = 0;
        fails       = 0;
        rst_watch   = 1'b0;
        rst_seen    = 1'b0;
        rst_pulses  = 0;
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;
        check_bit("core_en after reset", 1'b1, core_en);
        test_gpio_rw();
        test_read_only();
        test_debounce();
        test_shutdown();
        test_reset_request();
        test_rtc_rate();
        $display("Done: %0d value errors, %0d other failures", errors, fails);
        if (errors == 0 && fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: board_ctl.f
rtl/board_pkg.sv
rtl/input_debounce.sv
rtl/gpio_regs.sv
rtl/pmu_regs.sv
rtl/apb_periph_mux.sv
rtl/board_ctl_top.sv
dv/board_ctl_tb.sv

// File: Makefile
all: run

obj_dir/Vboard_ctl_tb: board_ctl.f rtl/*.sv dv/*.sv
	verilator --binary --timing -f board_ctl.f --top-module board_ctl_tb -o Vboard_ctl_tb

run: obj_dir/Vboard_ctl_tb
	./obj_dir/Vboard_ctl_tb | tee sim.log
	grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -f board_ctl.f --top-module board_ctl_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
